// ==== all.f ====
+incdir+include
logic/number_format_pkg.sv
logic/convert_ops_pkg.sv
logic/rounding_engine.sv
logic/fixed_to_float.sv
logic/float_to_fixed.sv
logic/convert_unit.sv
bench/convert_unit_tb.sv

// ==== bench/convert_tests.txt ====
# name  opcode(0 to float, 1 to fixed)  input word  expected word, all hex
# Fixed inputs are Q15.16, float words are IEEE-754 single
fx_one           0 00010000 3F800000
fl_one           1 3F800000 00010000
fx_neg_two_half  0 FFFD8000 C0200000
fl_neg_two_half  1 C0200000 FFFD8000
fx_min_frac      0 00000001 37800000
fl_third         1 3EAAAAAB 00005555
fx_zero          0 00000000 00000000
fl_trunc_pos     1 37C00000 00000001
fx_most_neg      0 80000000 C7000000
fl_trunc_neg     1 B7C00000 FFFFFFFF
fx_tie_even      0 01000001 43800000
fl_max_in_range  1 46FFFE00 7FFF0000
fx_tie_odd       0 01000003 43800002
fl_sat_pos       1 47800000 7FFFFFFF
fx_carry_exp     0 01FFFFFF 44000000
fl_sat_neg       1 C7000000 80000000
fx_max_pos       0 7FFFFFFF 47000000
fl_pos_inf       1 7F800000 7FFFFFFF
fx_neg_exact24   0 FF000001 C37FFFFF
fl_neg_inf       1 FF800000 80000000
fl_nan           1 FFC00001 7FFFFFFF
fl_tiny          1 37000000 00000000
fl_subnormal     1 00000001 00000000

// ==== bench/convert_unit_tb.sv ====
//----------------------------------------
// Conversion unit testbench
// Replays vectors from the tests file with
// random idle gaps and checks each result
// in order, with its tag and latency
//----------------------------------------
`timescale 1ns/1ps
`include "convert_defines.svh"

module convert_unit_tb
    import convert_ops_pkg::*;
();

    logic          clock = 1'b0;
    logic          reset;
    conv_request_t request;
    conv_result_t  result;

    int            error_count;
    int            checked_count;
    int            cycle_count;

    // Outstanding expectations, oldest first
    string                  expected_name [$];
    conv_op_t               expected_op   [$];
    logic [`CONV_WIDTH-1:0] expected_data [$];
    int                     expected_cycle[$];

    convert_unit dut_i (
        .clock   (clock),
        .reset   (reset),
        .request (request),
        .result  (result)
    );

    // 4 ns period
    always #2 clock = ~clock;

    // Edge counter for the latency check
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    //----------------------------------------
    // Helpers
    //----------------------------------------
    task automatic check_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s %s: expected %h, actual %h", test_name, field, expected, actual);
        end
    endtask

    // One request, 1 ns after the edge
    task automatic drive_request(input conv_op_t op, input logic [31:0] data);
        @(posedge clock);
        #1;
        request.valid = 1'b1;
        request.op    = op;
        request.data  = data;
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        #1;
        request.valid = 1'b0;
    endtask

    //----------------------------------------
    // Monitor, samples away from the edge
    //----------------------------------------
    always @(negedge clock) begin
        if (reset !== 1'b1) begin
            // Valid must be a clean zero while reset is held
            if (result.valid !== 1'b0) begin
                error_count++;
                $display("Result valid is not low during reset");
            end
        end else if (result.valid !== 1'b0 && result.valid !== 1'b1) begin
            error_count++;
            $display("Result valid is unknown after reset");
        end else if (result.valid === 1'b1) begin
            if (expected_data.size() == 0) begin
                error_count++;
                $display("Result valid with no request outstanding");
            end else begin
                check_value(expected_name[0], "data", expected_data[0], result.data);
                check_value(expected_name[0], "op", {31'b0, expected_op[0]}, {31'b0, result.op});
                check_value(expected_name[0], "cycle", expected_cycle[0], cycle_count);
                checked_count++;
                void'(expected_name.pop_front());
                void'(expected_op.pop_front());
                void'(expected_data.pop_front());
                void'(expected_cycle.pop_front());
            end
        end
    end

    //----------------------------------------
    // Stimulus
    //----------------------------------------
    initial begin : stimulus
        int          fd;
        int          fields;
        int          wait_cycles;
        int unsigned gap;
        int unsigned seed_draw;
        string       line;
        string       name;
        logic [31:0] op_word;
        logic [31:0] in_word;
        logic [31:0] exp_word;

        reset         = 1'b0;
        request       = '0;
        error_count   = 0;
        checked_count = 0;
        cycle_count   = 0;
        seed_draw     = $urandom(32'h64be);

        // Reset low for three edges
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b1;

        fd = $fopen("bench/convert_tests.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the test vector file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h", name, op_word, in_word, exp_word);
                    if (fields != 4) begin
                        error_count++;
                        $display("Malformed test vector line: %s", line);
                    end else begin
                        // Zero to two idle cycles before each request
                        gap = $urandom % 3;
                        repeat (gap) idle_cycle();
                        drive_request(conv_op_t'(op_word[0]), in_word);
                        expected_name.push_back(name);
                        expected_op.push_back(conv_op_t'(op_word[0]));
                        expected_data.push_back(exp_word);
                        // Fixed three-edge latency
                        expected_cycle.push_back(cycle_count + 3);
                    end
                end
            end
            $fclose(fd);
        end
        idle_cycle();

        // Drain with a bounded wait
        wait_cycles = 0;
        while (expected_data.size() > 0 && wait_cycles < 50) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (expected_data.size() > 0) begin
            error_count++;
            $display("Timeout, results stopped arriving with %0d outstanding",
                     expected_data.size());
        end

        // A few more edges to catch stray results
        repeat (5) @(posedge clock);

        $display("Results checked: %0d, errors: %0d", checked_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/convert_unit.sv ====
//--------------------------------------
// Fixed-point/float32 conversion unit
// Steers requests by opcode and merges
// the two three-cycle result streams
//--------------------------------------
`timescale 1ns/1ps
`include "convert_defines.svh"

module convert_unit
    import number_format_pkg::*;
    import convert_ops_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  conv_request_t request,
    output conv_result_t  result
);

    logic                   to_float_valid;
    logic                   to_fixed_valid;
    logic                   float_out_valid;
    float32_t               float_out_data;
    logic                   fixed_out_valid;
    logic [`CONV_WIDTH-1:0] fixed_out_data;
    // Opcode tag, same depth as the converters
    conv_op_t               op_pipe [3];

    // Exactly one converter sees each request
    assign to_float_valid = request.valid && (request.op == OP_TO_FLOAT);
    assign to_fixed_valid = request.valid && (request.op == OP_TO_FIXED);

    fixed_to_float #(
        .FRAC_BITS (`CONV_FRAC_BITS)
    ) to_float_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (to_float_valid),
        .in_data   (request.data),
        .out_valid (float_out_valid),
        .out_data  (float_out_data)
    );

    float_to_fixed #(
        .FRAC_BITS (`CONV_FRAC_BITS)
    ) to_fixed_i (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (to_fixed_valid),
        .in_data   (float32_t'(request.data)),
        .out_valid (fixed_out_valid),
        .out_data  (fixed_out_data)
    );

    always_ff @(posedge clock) begin
        op_pipe[0] <= request.op;
        op_pipe[1] <= op_pipe[0];
        op_pipe[2] <= op_pipe[1];
    end

    // Equal latency keeps the streams apart, a plain mux merges them
    assign result.valid = float_out_valid | fixed_out_valid;
    assign result.op    = op_pipe[2];
    assign result.data  = float_out_valid ? float_out_data : fixed_out_data;

    // Both paths finishing together would lose a result
    assert property (@(posedge clock) disable iff (!reset)
        !(float_out_valid && fixed_out_valid));

endmodule

// ==== logic/float_to_fixed.sv ====
//--------------------------------------
// Float32 to fixed-point converter
// Three stages: unpack and classify,
// alignment shift, sign and saturate
// Truncates toward zero
//--------------------------------------
`timescale 1ns/1ps
`include "convert_defines.svh"

module float_to_fixed
    import number_format_pkg::*;
#(
    parameter int FRAC_BITS = `CONV_FRAC_BITS
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    input  float32_t               in_data,
    output logic                   out_valid,
    output logic [`CONV_WIDTH-1:0] out_data
);

    // Magnitude bits left once the sign is set aside
    localparam int ALIGN_W = `CONV_WIDTH - 1;
    localparam logic [`CONV_WIDTH-1:0] MAX_POS = {1'b0, {(`CONV_WIDTH-1){1'b1}}};
    localparam logic [`CONV_WIDTH-1:0] MAX_NEG = {1'b1, {(`CONV_WIDTH-1){1'b0}}};

    // Input classes, subnormals are treated as zero
    typedef enum logic [1:0] {
        CLASS_ZERO,
        CLASS_NORMAL,
        CLASS_INF,
        CLASS_NAN
    } float_class_t;

    logic                       s1_valid;
    float_class_t               s1_class;
    logic                       s1_sign;
    logic [`FLOAT_EXP_BITS-1:0] s1_exponent;
    logic [`FLOAT_MAN_BITS:0]   s1_significand;

    logic                       s2_valid;
    float_class_t               s2_class;
    logic                       s2_sign;
    logic                       s2_overflow;
    logic [ALIGN_W-1:0]         s2_aligned;

    //--------------------------------------
    // Stage 1, unpack and classify
    //--------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            s1_sign        <= in_data.sign;
            s1_exponent    <= in_data.exponent;
            // Hidden bit restored in front of the fraction
            s1_significand <= {1'b1, in_data.mantissa};
            if (in_data.exponent == '0) begin
                s1_class <= CLASS_ZERO;
            end else if (&in_data.exponent) begin
                s1_class <= (in_data.mantissa == '0) ? CLASS_INF : CLASS_NAN;
            end else begin
                s1_class <= CLASS_NORMAL;
            end
        end
    end

    //--------------------------------------
    // Stage 2, alignment to the binary point
    //--------------------------------------
    int                 shift_amount;
    logic [ALIGN_W-1:0] widened;
    logic [ALIGN_W-1:0] aligned;
    logic               overflow;

    always_comb begin
        // Positive means shift left
        shift_amount = int'(s1_exponent) - `FLOAT_BIAS + FRAC_BITS - `FLOAT_MAN_BITS;
        widened      = {{(ALIGN_W-`FLOAT_MAN_BITS-1){1'b0}}, s1_significand};
        // Leading one past bit 30 does not fit
        overflow     = shift_amount >= (ALIGN_W - `FLOAT_MAN_BITS);
        if (shift_amount >= 0) begin
            aligned = widened << shift_amount;
        end else begin
            // Dropped bits give truncation toward zero
            aligned = widened >> (-shift_amount);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (s1_valid) begin
            s2_class    <= s1_class;
            s2_sign     <= s1_sign;
            s2_overflow <= overflow;
            s2_aligned  <= aligned;
        end
    end

    //--------------------------------------
    // Stage 3, sign and saturation
    //--------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (s2_valid) begin
            if (s2_class == CLASS_NAN) begin
                out_data <= MAX_POS;
            end else if (s2_class == CLASS_INF || s2_overflow) begin
                out_data <= s2_sign ? MAX_NEG : MAX_POS;
            end else if (s2_class == CLASS_ZERO) begin
                out_data <= '0;
            end else if (s2_sign) begin
                out_data <= ~{1'b0, s2_aligned} + 1'b1;
            end else begin
                out_data <= {1'b0, s2_aligned};
            end
        end
    end

    // Fixed three-cycle latency through the pipe
    assert property (@(posedge clock) disable iff (!reset)
        (in_valid === 1'b1) |-> ##3 (out_valid === 1'b1));

endmodule

// ==== logic/fixed_to_float.sv ====
//--------------------------------------
// Fixed-point to float32 converter
// Three stages: sign and magnitude,
// leading-one search, then exponent,
// rounded mantissa and pack
//--------------------------------------
`timescale 1ns/1ps
`include "convert_defines.svh"

module fixed_to_float
    import number_format_pkg::*;
#(
    parameter int FRAC_BITS = `CONV_FRAC_BITS
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [`CONV_WIDTH-1:0] in_data,
    output logic                   out_valid,
    output float32_t               out_data
);

    // Magnitude widened so a left shift never drops bits
    localparam int NORM_W = `CONV_WIDTH + `FLOAT_MAN_BITS + 1;

    logic       s1_valid;
    magnitude_t s1_value;
    logic       s2_valid;
    magnitude_t s2_value;
    logic [5:0] s2_msb;

    // Highest set bit, zero when the value is zero
    function automatic logic [5:0] msb_position(input logic [`CONV_WIDTH:0] value);
        logic [5:0] index;
        index = '0;
        for (int i = 0; i <= `CONV_WIDTH; i++) begin
            if (value[i]) index = 6'(i);
        end
        return index;
    endfunction

    //--------------------------------------
    // Stage 1, sign and absolute value
    //--------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            s1_value.sign <= in_data[`CONV_WIDTH-1];
            // Negate in the wide form so the most negative word is safe
            if (in_data[`CONV_WIDTH-1]) begin
                s1_value.magnitude <= ~{1'b1, in_data} + 1'b1;
            end else begin
                s1_value.magnitude <= {1'b0, in_data};
            end
        end
    end

    //--------------------------------------
    // Stage 2, leading-one detection
    //--------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (s1_valid) begin
            s2_value <= s1_value;
            s2_msb   <= msb_position(s1_value.magnitude);
        end
    end

    //--------------------------------------
    // Stage 3, exponent, mantissa and pack
    //--------------------------------------
    int                         exponent_full;
    logic [`FLOAT_EXP_BITS-1:0] exponent;
    logic [NORM_W-1:0]          widened;
    logic [NORM_W-1:0]          normalised;
    logic [`FLOAT_MAN_BITS-1:0] mantissa;
    logic                       round_up;

    always_comb begin
        // Bias plus binary point offset of the leading one
        exponent_full = `FLOAT_BIAS + int'(s2_msb) - FRAC_BITS;
        exponent      = exponent_full[`FLOAT_EXP_BITS-1:0];
        widened       = {{`FLOAT_MAN_BITS{1'b0}}, s2_value.magnitude};
        // Leading one lands on bit 23, the hidden bit
        if (s2_msb <= 6'(`FLOAT_MAN_BITS)) begin
            normalised = widened << (6'(`FLOAT_MAN_BITS) - s2_msb);
        end else begin
            normalised = widened >> (s2_msb - 6'(`FLOAT_MAN_BITS));
        end
        mantissa = normalised[`FLOAT_MAN_BITS-1:0];
    end

    rounding_engine rounder_i (
        .magnitude    (s2_value.magnitude),
        .msb_index    (s2_msb),
        .mantissa_lsb (normalised[0]),
        .round_up     (round_up)
    );

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (s2_valid) begin
            if (s2_value.magnitude == '0) begin
                // Zero always packs as positive zero
                out_data <= '0;
            end else if (round_up && (&mantissa)) begin
                // Mantissa wraps, carry moves into the exponent
                out_data <= '{sign: s2_value.sign, exponent: exponent + 1'b1, mantissa: '0};
            end else begin
                out_data <= '{sign: s2_value.sign, exponent: exponent,
                              mantissa: mantissa + {{(`FLOAT_MAN_BITS-1){1'b0}}, round_up}};
            end
        end
    end

    // Nonzero result never looks subnormal
    assert property (@(posedge clock) disable iff (!reset)
        (out_valid && (out_data != '0)) |-> (out_data.exponent != '0));

endmodule

// ==== logic/rounding_engine.sv ====
//--------------------------------------
// Round-to-nearest-even decision
// Looks at the bits dropped below the
// kept mantissa and says whether to add
// one ulp
//--------------------------------------
`timescale 1ns/1ps
`include "convert_defines.svh"

module rounding_engine (
    input  logic [`CONV_WIDTH:0] magnitude,
    input  logic [5:0]           msb_index,
    input  logic                 mantissa_lsb,
    output logic                 round_up
);

    // Guard sits one place below the last kept bit
    logic [5:0]           guard_index;
    logic [`CONV_WIDTH:0] sticky_mask;
    logic                 guard_bit;
    logic                 sticky_bit;

    always_comb begin
        guard_index = '0;
        sticky_mask = '0;
        guard_bit   = 1'b0;
        sticky_bit  = 1'b0;
        round_up    = 1'b0;
        // Up to 24 significant bits fit, nothing lost
        if (msb_index > 6'(`FLOAT_MAN_BITS)) begin
            guard_index = msb_index - 6'(`FLOAT_MAN_BITS + 1);
            guard_bit   = magnitude[guard_index];
            // Everything under the guard folds into sticky
            sticky_mask = ({{`CONV_WIDTH{1'b0}}, 1'b1} << guard_index) - 1'b1;
            sticky_bit  = |(magnitude & sticky_mask);
            // Above half rounds up, exact half only when LSB is odd
            round_up    = guard_bit & (sticky_bit | mantissa_lsb);
        end
    end

endmodule

// ==== logic/convert_ops_pkg.sv ====
//--------------------------------------
// Conversion unit request/result types
// Opcode and the two stream structs
//--------------------------------------
`include "convert_defines.svh"

package convert_ops_pkg;

    // Direction of the conversion
    typedef enum logic [0:0] {
        OP_TO_FLOAT = 1'b0,
        OP_TO_FIXED = 1'b1
    } conv_op_t;

    // Incoming request, one per valid cycle
    typedef struct packed {
        logic                    valid;
        conv_op_t                op;
        logic [`CONV_WIDTH-1:0]  data;
    } conv_request_t;

    // Outgoing result, tagged with the opcode that made it
    typedef struct packed {
        logic                    valid;
        conv_op_t                op;
        logic [`CONV_WIDTH-1:0]  data;
    } conv_result_t;

endpackage

// ==== logic/number_format_pkg.sv ====
//--------------------------------------
// Number format types
// Float32 fields and the sign/magnitude
// form used inside the converters
//--------------------------------------
`include "convert_defines.svh"

package number_format_pkg;

    // IEEE-754 single, MSB first
    typedef struct packed {
        logic                         sign;
        logic [`FLOAT_EXP_BITS-1:0]   exponent;
        logic [`FLOAT_MAN_BITS-1:0]   mantissa;
    } float32_t;

    // Sign and absolute value of a fixed-point word
    // One extra bit so the most negative word still fits
    typedef struct packed {
        logic                  sign;
        logic [`CONV_WIDTH:0]  magnitude;
    } magnitude_t;

endpackage

// ==== include/convert_defines.svh ====
//--------------------------------------
// Conversion unit parameters
// Fixed-point word size, fraction bits
// and the IEEE-754 single field layout
//--------------------------------------
`ifndef CONVERT_DEFINES_SVH
`define CONVERT_DEFINES_SVH

// Fixed-point word width
`define CONV_WIDTH 32
// Fraction bits, Q15.16 by default
`define CONV_FRAC_BITS 16

// Single precision layout
`define FLOAT_BIAS 127
`define FLOAT_EXP_BITS 8
`define FLOAT_MAN_BITS 23

`endif
